// ==== tempSensorReader.f ====
logic/tempSensorPkg.sv
logic/i2cBitEngine.sv
logic/i2cByteEngine.sv
logic/tempReadSequencer.sv
logic/tempSensorReader.sv
sim/tbClockGen.sv
sim/i2cSensorModel.sv
sim/tbTempSensorReader.sv

// ==== Bender.yml ====
package:
  name: temp_sensor_reader

sources:
  # RTL, package first
  - target: any(rtl, simulation)
    files:
      - logic/tempSensorPkg.sv
      - logic/i2cBitEngine.sv
      - logic/i2cByteEngine.sv
      - logic/tempReadSequencer.sv
      - logic/tempSensorReader.sv

  # testbench
  - target: simulation
    files:
      - sim/tbClockGen.sv
      - sim/i2cSensorModel.sv
      - sim/tbTempSensorReader.sv

// ==== sim/tbTempSensorReader.sv ====
module tbTempSensorReader;

    localparam int maxRequests      = 20;
    localparam int cyclesPerRequest = 400;
    localparam int clockPeriod      = 10;
    localparam int minLatency       = 336;
    localparam int watchdogTime     = maxRequests * cyclesPerRequest * clockPeriod;

    logic                    FSM_Clk;
    logic                    arstN;
    logic                    startValid;
    logic                    startReady;
    logic                    tempValid;
    logic                    tempReady;
    tempSensorPkg::temp_t    temp;
    logic                    ackError;
    logic                    scl;
    logic                    sdaOe;
    logic                    sdaIn;
    logic                    modelOe;
    logic                    ackEnable;
    tempSensorPkg::i2cByte_t regMsb;
    tempSensorPkg::i2cByte_t regLsb;
    int                      passCount;
    logic                    passShapeOk;
    tempSensorPkg::i2cByte_t passAddrW;
    tempSensorPkg::i2cByte_t passPointer;
    tempSensorPkg::i2cByte_t passAddrR;
    int                      checks;
    int                      errors;
    int                      requests;
    int                      results;
    logic                    prevTempValid;
    integer                  seed;

    // either side pulls the open drain SDA low
    assign sdaIn = !(sdaOe || modelOe);

    tbClockGen i_tbClockGen (.FSM_Clk(FSM_Clk), .arstN(arstN));

    tempSensorReader i_tempSensorReader (
        .FSM_Clk(FSM_Clk), .arstN(arstN), .startValid(startValid), .startReady(startReady),
        .tempValid(tempValid), .tempReady(tempReady), .temp(temp), .ackError(ackError),
        .scl(scl), .sdaOe(sdaOe), .sdaIn(sdaIn)
    );

    i2cSensorModel i_i2cSensorModel (
        .arstN(arstN), .scl(scl), .sda(sdaIn), .ackEnable(ackEnable), .regMsb(regMsb),
        .regLsb(regLsb), .modelOe(modelOe), .passCount(passCount), .passShapeOk(passShapeOk),
        .passAddrW(passAddrW), .passPointer(passPointer), .passAddrR(passAddrR)
    );

    task automatic expectTrue(input logic ok, input string msg);
        checks++;
        assert (ok === 1'b1) else begin
            errors++;
            $display("FAILED at %0t: %s", $time, msg);
        end
    endtask

    task automatic runRequest(input int holdCycles);
        int                   cycles;
        tempSensorPkg::temp_t heldTemp;
        logic                 heldErr;
        expectTrue(startReady, "startReady low before a request");
        startValid = 1'b1;
        @(posedge FSM_Clk);
        #1;
        startValid = 1'b0;
        requests++;
        expectTrue(!startReady, "startReady still high after acceptance");
        cycles = 0;
        while (tempValid !== 1'b1) begin
            @(posedge FSM_Clk);
            #1;
            cycles++;
        end
        expectTrue(cycles >= minLatency, $sformatf("result after only %0d cycles", cycles));
        heldTemp = temp;
        heldErr  = ackError;
        repeat (holdCycles) begin
            @(posedge FSM_Clk);
            #1;
            expectTrue(tempValid && temp === heldTemp && ackError === heldErr,
                       "result changed while tempReady low");
            expectTrue(!startReady && scl && sdaIn, "bus or startReady not idle while held");
        end
        if (ackEnable) begin
            expectTrue(temp === {regMsb, regLsb} && !ackError,
                       $sformatf("temp %h ackError %b, expected %h", temp, ackError,
                                 {regMsb, regLsb}));
        end else begin
            expectTrue(ackError, "ackError low without sensor acknowledge");
        end
        tempReady = 1'b1;
        @(posedge FSM_Clk);
        #1;
        tempReady = 1'b0;
        expectTrue(!tempValid && startReady, "result not released after transfer");
    endtask

    // each rise of tempValid is one result
    always @(posedge FSM_Clk) begin
        if (tempValid === 1'b1 && prevTempValid !== 1'b1) begin
            results++;
        end
        prevTempValid = tempValid;
    end

    // odd passes read the MSB pointer
    always @(passCount) begin
        #1;
        if (passCount > 0) begin
            expectTrue(passShapeOk, "register read framing wrong on the bus");
            expectTrue(passAddrW === {7'h48, 1'b0}, $sformatf("write address %h", passAddrW));
            expectTrue(passAddrR === {7'h48, 1'b1}, $sformatf("read address %h", passAddrR));
            expectTrue(passPointer === ((passCount % 2) ? 8'h00 : 8'h01),
                       $sformatf("pointer %h in pass %0d", passPointer, passCount));
        end
    end

    initial begin
        #(watchdogTime);
        $display("watchdog expired after %0d time units, the run did not finish", watchdogTime);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        startValid    = 1'b0;
        tempReady     = 1'b0;
        ackEnable     = 1'b1;
        regMsb        = '0;
        regLsb        = '0;
        prevTempValid = 1'b0;
        seed          = 32'hd83d497b;
        @(posedge arstN);
        @(posedge FSM_Clk);
        #1;
        expectTrue(scl && sdaIn && !tempValid && startReady, "idle state after reset wrong");
        repeat (12) begin
            regMsb = 8'($random(seed));
            regLsb = 8'($random(seed));
            runRequest(0);
        end
        ackEnable = 1'b0;
        runRequest(0);
        ackEnable = 1'b1;
        // back-pressure on the result port
        repeat (2) begin
            regMsb = 8'($random(seed));
            regLsb = 8'($random(seed));
            runRequest(1 + ($random(seed) & 63));
        end
        repeat (4) @(posedge FSM_Clk);
        #1;
        expectTrue(results == requests, $sformatf("%0d results for %0d requests", results,
                                                  requests));
        expectTrue(passCount == 2 * requests, $sformatf("%0d register reads seen", passCount));
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/i2cSensorModel.sv ====
module i2cSensorModel (
    input  logic                    arstN,
    input  logic                    scl,
    input  logic                    sda,
    input  logic                    ackEnable,
    input  tempSensorPkg::i2cByte_t regMsb,
    input  tempSensorPkg::i2cByte_t regLsb,
    output logic                    modelOe,
    output int                      passCount,
    output logic                    passShapeOk,
    output tempSensorPkg::i2cByte_t passAddrW,
    output tempSensorPkg::i2cByte_t passPointer,
    output tempSensorPkg::i2cByte_t passAddrR
);

    tempSensorPkg::i2cAddrByte_t addrIn;
    tempSensorPkg::i2cByte_t     shiftIn;
    tempSensorPkg::i2cByte_t     pointer;
    tempSensorPkg::i2cByte_t     txData;
    tempSensorPkg::i2cByte_t     frameByte [0:3];
    logic [3:0]                  frameAck;
    logic                        sampled;
    logic                        pending;
    logic                        inPass;
    logic                        addrFrame;
    logic                        addressed;
    logic                        readMode;
    logic                        shapeBad;
    int                          bitCnt;
    int                          frameIdx;
    int                          repAt;

    initial begin
        modelOe   = 1'b0;
        passCount = 0;
        pending   = 1'b0;
        inPass    = 1'b0;
        addressed = 1'b0;
        readMode  = 1'b0;
        pointer   = '0;
        bitCnt    = 0;
    end

    // start or repeated start
    always @(negedge sda) begin
        if (arstN === 1'b1 && scl === 1'b1) begin
            if (inPass) begin
                shapeBad = shapeBad || (bitCnt != 0) || (repAt >= 0);
                repAt    = frameIdx;
            end else begin
                inPass   = 1'b1;
                frameIdx = 0;
                repAt    = -1;
                shapeBad = 1'b0;
            end
            bitCnt    = 0;
            pending   = 1'b0;
            addrFrame = 1'b1;
        end
    end

    // stop, publish what this pass looked like
    always @(posedge sda) begin
        if (arstN === 1'b1 && scl === 1'b1 && inPass) begin
            passShapeOk = !shapeBad && (bitCnt == 0) && (frameIdx == 4) && (repAt == 2) &&
                          frameAck[3];
            passAddrW   = frameByte[0];
            passPointer = frameByte[1];
            passAddrR   = frameByte[2];
            inPass      = 1'b0;
            pending     = 1'b0;
            addressed   = 1'b0;
            bitCnt      = 0;
            passCount++;
        end
    end

    // a bit only counts once SCL falls without a condition in between
    always @(posedge scl) begin
        if (arstN === 1'b1 && inPass) begin
            sampled = sda;
            pending = 1'b1;
        end
    end

    always @(negedge scl) begin
        if (arstN === 1'b1 && inPass && pending) begin
            pending = 1'b0;
            if (bitCnt < 8) begin
                shiftIn = {shiftIn[6:0], sampled};
                bitCnt++;
                if (bitCnt == 8 && addrFrame) begin
                    addrIn.raw = shiftIn;
                    addressed  = ackEnable && (addrIn.fields.devAddr == tempSensorPkg::sensorAddr);
                    readMode   = addrIn.fields.rw;
                    txData     = (pointer == tempSensorPkg::pointerMsb) ? regMsb : regLsb;
                end else if (bitCnt == 8 && addressed && !readMode) begin
                    pointer = shiftIn;
                end
            end else begin
                if (frameIdx < 4) begin
                    frameByte[frameIdx] = shiftIn;
                    frameAck[frameIdx]  = sampled;
                end
                frameIdx++;
                // master NACK ends the read
                if (readMode && !addrFrame && sampled) begin
                    addressed = 1'b0;
                end
                addrFrame = 1'b0;
                bitCnt    = 0;
            end
            #1;
            if (bitCnt == 8) begin
                modelOe = addressed && (addrFrame || !readMode);
            end else begin
                modelOe = addressed && readMode && !addrFrame && !txData[7 - bitCnt];
            end
        end
    end

endmodule

// ==== sim/tbClockGen.sv ====
module tbClockGen (
    output logic FSM_Clk,
    output logic arstN
);

    localparam int halfPeriod  = 5;
    localparam int resetCycles = 5;

    initial begin
        FSM_Clk = 1'b0;
        forever #halfPeriod FSM_Clk = ~FSM_Clk;
    end

    // release just after an edge, like the other inputs
    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge FSM_Clk);
        #1 arstN = 1'b1;
    end

endmodule

// ==== logic/tempSensorReader.sv ====
module tempSensorReader (
    input  logic                 FSM_Clk,
    input  logic                 arstN,
    input  logic                 startValid,
    output logic                 startReady,
    output logic                 tempValid,
    input  logic                 tempReady,
    output tempSensorPkg::temp_t temp,
    output logic                 ackError,
    output logic                 scl,
    output logic                 sdaOe,
    input  logic                 sdaIn
);

    logic                    byteValid;
    logic                    byteReady;
    tempSensorPkg::byteCmd_t byteCmd;
    tempSensorPkg::i2cByte_t txByte;
    logic                    byteDone;
    tempSensorPkg::i2cByte_t rxByte;
    logic                    ackIn;

    logic                    bitValid;
    logic                    bitReady;
    tempSensorPkg::bitCmd_t  bitCmd;
    logic                    bitData;
    logic                    bitDone;
    logic                    rxBit;

    tempReadSequencer i_tempReadSequencer (
        .FSM_Clk    (FSM_Clk),
        .arstN      (arstN),
        .startValid (startValid),
        .startReady (startReady),
        .tempValid  (tempValid),
        .tempReady  (tempReady),
        .temp       (temp),
        .ackError   (ackError),
        .byteValid  (byteValid),
        .byteReady  (byteReady),
        .byteCmd    (byteCmd),
        .txByte     (txByte),
        .byteDone   (byteDone),
        .rxByte     (rxByte),
        .ackIn      (ackIn)
    );

    i2cByteEngine i_i2cByteEngine (
        .FSM_Clk   (FSM_Clk),
        .arstN     (arstN),
        .byteValid (byteValid),
        .byteReady (byteReady),
        .byteCmd   (byteCmd),
        .txByte    (txByte),
        .byteDone  (byteDone),
        .rxByte    (rxByte),
        .ackIn     (ackIn),
        .bitValid  (bitValid),
        .bitReady  (bitReady),
        .bitCmd    (bitCmd),
        .bitData   (bitData),
        .bitDone   (bitDone),
        .rxBit     (rxBit)
    );

    i2cBitEngine i_i2cBitEngine (
        .FSM_Clk  (FSM_Clk),
        .arstN    (arstN),
        .bitValid (bitValid),
        .bitReady (bitReady),
        .bitCmd   (bitCmd),
        .bitData  (bitData),
        .bitDone  (bitDone),
        .rxBit    (rxBit),
        .scl      (scl),
        .sdaOe    (sdaOe),
        .sdaIn    (sdaIn)
    );

endmodule

// ==== logic/tempReadSequencer.sv ====
module tempReadSequencer (
    input  logic                     FSM_Clk,
    input  logic                     arstN,
    input  logic                     startValid,
    output logic                     startReady,
    output logic                     tempValid,
    input  logic                     tempReady,
    output tempSensorPkg::temp_t     temp,
    output logic                     ackError,
    output logic                     byteValid,
    input  logic                     byteReady,
    output tempSensorPkg::byteCmd_t  byteCmd,
    output tempSensorPkg::i2cByte_t  txByte,
    input  logic                     byteDone,
    input  tempSensorPkg::i2cByte_t  rxByte,
    input  logic                     ackIn
);

    logic                        active;
    logic [2:0]                  step;
    logic                        half;
    tempSensorPkg::i2cAddrByte_t addrByte;

    assign startReady = !active && !tempValid;

    // steps of one register read
    //   0 start, 1 address write, 2 pointer, 3 repeated start,
    //   4 address read, 5 data byte, 6 stop
    always_comb begin
        case (step)
            3'd0:    byteCmd = tempSensorPkg::byteStart;
            3'd3:    byteCmd = tempSensorPkg::byteRepStart;
            3'd5:    byteCmd = tempSensorPkg::byteRead;
            3'd6:    byteCmd = tempSensorPkg::byteStop;
            default: byteCmd = tempSensorPkg::byteWrite;
        endcase
    end

    always_comb begin
        addrByte.fields.devAddr = tempSensorPkg::sensorAddr;
        addrByte.fields.rw      = (step == 3'd4);
        if (step == 3'd2) begin
            txByte = half ? tempSensorPkg::pointerLsb : tempSensorPkg::pointerMsb;
        end else begin
            txByte = addrByte.raw;
        end
    end

    always_ff @(posedge FSM_Clk or negedge arstN) begin
        if (!arstN) begin
            active    <= 1'b0;
            step      <= '0;
            half      <= 1'b0;
            byteValid <= 1'b0;
            tempValid <= 1'b0;
            ackError  <= 1'b0;
        end else begin
            if (startValid && startReady) begin
                active    <= 1'b1;
                step      <= '0;
                half      <= 1'b0;
                byteValid <= 1'b1;
                ackError  <= 1'b0;
            end
            if (byteValid && byteReady) begin
                byteValid <= 1'b0;
            end
            if (active && byteDone) begin
                ackError <= ackError | ackIn;
                if (step != 3'd6) begin
                    step      <= step + 3'd1;
                    byteValid <= 1'b1;
                end else if (!half) begin
                    // second pass for the LSB register
                    half      <= 1'b1;
                    step      <= '0;
                    byteValid <= 1'b1;
                end else begin
                    active    <= 1'b0;
                    tempValid <= 1'b1;
                end
            end
            if (tempValid && tempReady) begin
                tempValid <= 1'b0;
            end
        end
    end

    // result bytes, held while tempValid waits
    always_ff @(posedge FSM_Clk) begin
        if (active && byteDone && (step == 3'd5)) begin
            if (half) begin
                temp[7:0] <= rxByte;
            end else begin
                temp[15:8] <= rxByte;
            end
        end
    end

endmodule

// ==== logic/i2cByteEngine.sv ====
module i2cByteEngine (
    input  logic                     FSM_Clk,
    input  logic                     arstN,
    input  logic                     byteValid,
    output logic                     byteReady,
    input  tempSensorPkg::byteCmd_t  byteCmd,
    input  tempSensorPkg::i2cByte_t  txByte,
    output logic                     byteDone,
    output tempSensorPkg::i2cByte_t  rxByte,
    output logic                     ackIn,
    output logic                     bitValid,
    input  logic                     bitReady,
    output tempSensorPkg::bitCmd_t   bitCmd,
    output logic                     bitData,
    input  logic                     bitDone,
    input  logic                     rxBit
);

    logic                    busy;
    logic                    needIssue;
    tempSensorPkg::byteCmd_t cmdQ;
    tempSensorPkg::i2cByte_t shiftQ;
    logic [3:0]              slot;
    logic [3:0]              nextSlot;
    logic                    nextData;
    logic                    isCond;
    logic                    lastSlot;

    assign isCond = (cmdQ == tempSensorPkg::byteStart) ||
                    (cmdQ == tempSensorPkg::byteRepStart) ||
                    (cmdQ == tempSensorPkg::byteStop);

    // slot 8 carries the acknowledge
    assign lastSlot = isCond || (slot == 4'd8);

    // first bit right after acceptance, later ones in the bitDone cycle
    assign bitValid = busy && (needIssue || (bitDone && !lastSlot));
    assign nextSlot = needIssue ? slot : slot + 4'd1;
    assign nextData = needIssue ? shiftQ[7] : shiftQ[6];
    assign bitData  = (nextSlot == 4'd8) ? 1'b1 : nextData;

    always_comb begin
        case (cmdQ)
            tempSensorPkg::byteStart:    bitCmd = tempSensorPkg::cmdStart;
            tempSensorPkg::byteRepStart: bitCmd = tempSensorPkg::cmdRepStart;
            tempSensorPkg::byteStop:     bitCmd = tempSensorPkg::cmdStop;
            tempSensorPkg::byteWrite: begin
                bitCmd = (nextSlot == 4'd8) ? tempSensorPkg::cmdRead : tempSensorPkg::cmdWrite;
            end
            default: begin
                // master NACK after the eighth data bit
                bitCmd = (nextSlot == 4'd8) ? tempSensorPkg::cmdWrite : tempSensorPkg::cmdRead;
            end
        endcase
    end

    assign byteReady = !busy;
    assign byteDone  = busy && bitDone && lastSlot;
    assign rxByte    = shiftQ;
    assign ackIn     = (cmdQ == tempSensorPkg::byteWrite) && rxBit;

    always_ff @(posedge FSM_Clk or negedge arstN) begin
        if (!arstN) begin
            busy      <= 1'b0;
            needIssue <= 1'b0;
            cmdQ      <= tempSensorPkg::byteStop;
            slot      <= '0;
        end else if (byteValid && byteReady) begin
            busy      <= 1'b1;
            needIssue <= 1'b1;
            cmdQ      <= byteCmd;
            slot      <= '0;
        end else if (busy) begin
            if (bitValid && bitReady) begin
                needIssue <= 1'b0;
            end
            if (bitDone) begin
                if (lastSlot) begin
                    busy <= 1'b0;
                end else begin
                    slot <= slot + 4'd1;
                end
            end
        end
    end

    // MSB first out, read bits enter at the bottom
    always_ff @(posedge FSM_Clk) begin
        if (byteValid && byteReady) begin
            shiftQ <= txByte;
        end else if (busy && bitDone && !lastSlot) begin
            shiftQ <= {shiftQ[6:0], rxBit};
        end
    end

endmodule

// ==== logic/i2cBitEngine.sv ====
module i2cBitEngine (
    input  logic                   FSM_Clk,
    input  logic                   arstN,
    input  logic                   bitValid,
    output logic                   bitReady,
    input  tempSensorPkg::bitCmd_t bitCmd,
    input  logic                   bitData,
    output logic                   bitDone,
    output logic                   rxBit,
    output logic                   scl,
    output logic                   sdaOe,
    input  logic                   sdaIn
);

    typedef logic [$clog2(tempSensorPkg::quarterPhases)-1:0] phase_t;

    logic                   busy;
    phase_t                 phase;
    tempSensorPkg::bitCmd_t cmdQ;
    logic                   lastPhase;
    logic                   isStart;

    assign lastPhase = (phase == phase_t'(tempSensorPkg::quarterPhases - 1));
    assign isStart   = (cmdQ == tempSensorPkg::cmdStart) || (cmdQ == tempSensorPkg::cmdRepStart);

    // next command may start in the last quarter of the current one
    assign bitReady = !busy || lastPhase;
    assign bitDone  = busy && lastPhase;

    always_ff @(posedge FSM_Clk or negedge arstN) begin
        if (!arstN) begin
            busy  <= 1'b0;
            phase <= '0;
            cmdQ  <= tempSensorPkg::cmdStop;
            scl   <= 1'b1;
            sdaOe <= 1'b0;
            rxBit <= 1'b1;
        end else if (bitValid && bitReady) begin
            // quarter 0, SCL kept where it is
            busy  <= 1'b1;
            phase <= '0;
            cmdQ  <= bitCmd;
            case (bitCmd)
                tempSensorPkg::cmdWrite: sdaOe <= ~bitData;
                tempSensorPkg::cmdStop:  sdaOe <= 1'b1;
                default:                 sdaOe <= 1'b0;
            endcase
        end else if (busy) begin
            phase <= phase + phase_t'(1);
            case (phase)
                phase_t'(0): begin
                    scl <= 1'b1;
                end
                phase_t'(1): begin
                    // start and stop move SDA with SCL high
                    if (isStart) begin
                        sdaOe <= 1'b1;
                    end else if (cmdQ == tempSensorPkg::cmdStop) begin
                        sdaOe <= 1'b0;
                    end
                end
                phase_t'(2): begin
                    if (cmdQ == tempSensorPkg::cmdRead) begin
                        rxBit <= sdaIn;
                    end
                    // bus is released after stop, held low otherwise
                    scl <= (cmdQ == tempSensorPkg::cmdStop);
                end
                default: begin
                    busy <= 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== logic/tempSensorPkg.sv ====
package tempSensorPkg;

    // FSM_Clk cycles in one bit slot or bus condition
    localparam int quarterPhases = 4;

    // ADT7420 with both address pins low
    localparam logic [6:0] sensorAddr = 7'h48;

    typedef logic [7:0] i2cByte_t;

    // MSB register byte in [15:8], LSB register byte in [7:0]
    typedef logic [15:0] temp_t;

    // temperature register pointers
    localparam i2cByte_t pointerMsb = 8'h00;
    localparam i2cByte_t pointerLsb = 8'h01;

    // first byte after a start, seen as raw bits or as address and direction
    typedef union packed {
        i2cByte_t raw;
        struct packed {
            logic [6:0] devAddr;
            logic       rw;
        } fields;
    } i2cAddrByte_t;

    typedef enum logic [2:0] {
        cmdStart,
        cmdRepStart,
        cmdStop,
        cmdWrite,
        cmdRead
    } bitCmd_t;

    // conditions go through to the bit engine unchanged
    typedef enum logic [2:0] {
        byteStart,
        byteRepStart,
        byteStop,
        byteWrite,
        byteRead
    } byteCmd_t;

endpackage
